// ==== logic/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    typedef logic [31:0] word_t;     // Data word, PC and immediates.
    typedef logic [4:0]  reg_addr_t; // Register number or shift amount.

    typedef logic [2:0] src_a_sel_t;
    typedef logic [2:0] src_b_sel_t;
    typedef logic [5:0] alu_sel_t;
    typedef logic [2:0] res_sel_t;

    typedef enum logic [1:0] {
        SHIFT_LL,
        SHIFT_RL,
        SHIFT_RA
    } shift_dir_t;

    // Operand A sources.
    localparam src_a_sel_t SRC_A_SEL_NOP  = 3'd0;
    localparam src_a_sel_t SRC_A_SEL_ZERO = 3'd1;
    localparam src_a_sel_t SRC_A_SEL_RS   = 3'd2;
    localparam src_a_sel_t SRC_A_SEL_RT   = 3'd3;

    // Operand B sources.
    localparam src_b_sel_t SRC_B_SEL_NOP  = 3'd0;
    localparam src_b_sel_t SRC_B_SEL_ZERO = 3'd1;
    localparam src_b_sel_t SRC_B_SEL_RT   = 3'd2;
    localparam src_b_sel_t SRC_B_SEL_IMME = 3'd3;
    localparam src_b_sel_t SRC_B_SEL_RS   = 3'd4;
    localparam src_b_sel_t SRC_B_SEL_SA   = 3'd5;

    localparam alu_sel_t ALU_ADD  = 6'd1;
    localparam alu_sel_t ALU_ADDU = 6'd2;
    localparam alu_sel_t ALU_SUB  = 6'd3;
    localparam alu_sel_t ALU_SUBU = 6'd4;
    localparam alu_sel_t ALU_AND  = 6'd5;
    localparam alu_sel_t ALU_OR   = 6'd6;
    localparam alu_sel_t ALU_XOR  = 6'd7;
    localparam alu_sel_t ALU_NOR  = 6'd8;
    localparam alu_sel_t ALU_SLT  = 6'd9;
    localparam alu_sel_t ALU_SLTU = 6'd10;
    localparam alu_sel_t ALU_SLL  = 6'd11;
    localparam alu_sel_t ALU_SRL  = 6'd12;
    localparam alu_sel_t ALU_SRA  = 6'd13;
    localparam alu_sel_t ALU_LUI  = 6'd14;

    // Stage result sources.
    localparam res_sel_t RES_SEL_NOP  = 3'd0;
    localparam res_sel_t RES_SEL_ALU  = 3'd1;
    localparam res_sel_t RES_SEL_LINK = 3'd2;

    localparam word_t LINK_OFFSET = 32'd8; // Return address skips the delay slot.

endpackage

`default_nettype wire

// ==== logic/alu_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_shifter (
    input  ex_pkg::word_t      value,
    input  ex_pkg::reg_addr_t  amount,
    input  ex_pkg::shift_dir_t dir,
    output ex_pkg::word_t      result
);

    ex_pkg::word_t stage [6];
    logic          fill;

    // Sign bit only for arithmetic right shifts.
    assign fill = (dir == ex_pkg::SHIFT_RA) ? value[31] : 1'b0;

    assign stage[0] = value;

    // Stage i shifts by 2**i when amount bit i is set.
    for (genvar i = 0; i < 5; i++) begin : g_stage
        localparam int N = 1 << i;

        assign stage[i+1] =
            !amount[i]              ? stage[i] :
            (dir == ex_pkg::SHIFT_LL) ? {stage[i][31-N:0], {N{1'b0}}} :
                                      {{N{fill}}, stage[i][31:N]};
    end

    assign result = stage[5];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  ex_pkg::word_t    src_a,
    input  ex_pkg::word_t    src_b,
    input  ex_pkg::alu_sel_t alu_sel,
    output ex_pkg::word_t    alu_res,
    output logic             alu_ovf
);

    logic               sub;
    ex_pkg::word_t      b_op;
    ex_pkg::word_t      sum;
    logic               carry;
    logic               ovf_raw;
    ex_pkg::shift_dir_t shift_dir;
    ex_pkg::word_t      shift_res;

    // Compares run through the subtractor too.
    assign sub = (alu_sel == ex_pkg::ALU_SUB)  || (alu_sel == ex_pkg::ALU_SUBU) ||
                 (alu_sel == ex_pkg::ALU_SLT)  || (alu_sel == ex_pkg::ALU_SLTU);

    assign b_op = sub ? ~src_b : src_b;
    assign {carry, sum} = {1'b0, src_a} + {1'b0, b_op} + {32'd0, sub};

    // Operands of equal sign giving a result of the other sign.
    assign ovf_raw = (src_a[31] == b_op[31]) && (sum[31] != src_a[31]);

    assign alu_ovf = ovf_raw &&
                     ((alu_sel == ex_pkg::ALU_ADD) || (alu_sel == ex_pkg::ALU_SUB));

    always_comb begin
        case (alu_sel)
            ex_pkg::ALU_SRL: shift_dir = ex_pkg::SHIFT_RL;
            ex_pkg::ALU_SRA: shift_dir = ex_pkg::SHIFT_RA;
            default:         shift_dir = ex_pkg::SHIFT_LL;
        endcase
    end

    alu_shifter u_shifter (
        .value  (src_a),
        .amount (src_b[4:0]),
        .dir    (shift_dir),
        .result (shift_res)
    );

    always_comb begin
        case (alu_sel)
            ex_pkg::ALU_ADD,
            ex_pkg::ALU_ADDU,
            ex_pkg::ALU_SUB,
            ex_pkg::ALU_SUBU: alu_res = sum;
            ex_pkg::ALU_AND:  alu_res = src_a & src_b;
            ex_pkg::ALU_OR:   alu_res = src_a | src_b;
            ex_pkg::ALU_XOR:  alu_res = src_a ^ src_b;
            ex_pkg::ALU_NOR:  alu_res = ~(src_a | src_b);
            ex_pkg::ALU_SLT:  alu_res = {31'd0, sum[31] ^ ovf_raw}; // True sign of a - b.
            ex_pkg::ALU_SLTU: alu_res = {31'd0, ~carry};            // Borrow out.
            ex_pkg::ALU_SLL,
            ex_pkg::ALU_SRL,
            ex_pkg::ALU_SRA:  alu_res = shift_res;
            ex_pkg::ALU_LUI:  alu_res = {src_b[15:0], 16'd0};
            default:          alu_res = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ex_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
    input  logic               id2_in_delay_slot,
    input  ex_pkg::reg_addr_t  id2_w_reg_dst,
    input  ex_pkg::reg_addr_t  id2_sa,
    input  ex_pkg::word_t      id2_rs_data,
    input  ex_pkg::word_t      id2_rt_data,
    input  ex_pkg::word_t      id2_ext_imme,
    input  ex_pkg::word_t      id2_pc,
    input  ex_pkg::src_a_sel_t id2_src_a_sel,
    input  ex_pkg::src_b_sel_t id2_src_b_sel,
    input  ex_pkg::alu_sel_t   id2_alu_sel,
    input  ex_pkg::res_sel_t   id2_alu_res_sel,
    input  logic               id2_w_reg_ena,
    input  logic               id2_wb_reg_sel,
    output ex_pkg::word_t      ex_alu_res,
    output logic               ex_ovf,
    output logic               ex_in_delay_slot,
    output ex_pkg::word_t      ex_pc,
    output ex_pkg::word_t      ex_rt_data,
    output logic               ex_w_reg_ena,
    output ex_pkg::reg_addr_t  ex_w_reg_dst,
    output logic               ex_wb_reg_sel
);

    ex_pkg::word_t src_a;
    ex_pkg::word_t src_b;
    ex_pkg::word_t alu_res;
    logic          alu_ovf;

    // Nop, zero and unused codes fall to zero.
    always_comb begin
        case (id2_src_a_sel)
            ex_pkg::SRC_A_SEL_RS: src_a = id2_rs_data;
            ex_pkg::SRC_A_SEL_RT: src_a = id2_rt_data;
            default:              src_a = '0;
        endcase
    end

    always_comb begin
        case (id2_src_b_sel)
            ex_pkg::SRC_B_SEL_RT:   src_b = id2_rt_data;
            ex_pkg::SRC_B_SEL_IMME: src_b = id2_ext_imme;
            ex_pkg::SRC_B_SEL_RS:   src_b = id2_rs_data;
            ex_pkg::SRC_B_SEL_SA:   src_b = {27'd0, id2_sa};
            default:                src_b = '0;
        endcase
    end

    alu u_alu (
        .src_a   (src_a),
        .src_b   (src_b),
        .alu_sel (id2_alu_sel),
        .alu_res (alu_res),
        .alu_ovf (alu_ovf)
    );

    always_comb begin
        case (id2_alu_res_sel)
            ex_pkg::RES_SEL_ALU:  ex_alu_res = alu_res;
            ex_pkg::RES_SEL_LINK: ex_alu_res = id2_pc + ex_pkg::LINK_OFFSET; // Jump-and-link.
            default:              ex_alu_res = '0;
        endcase
    end

    assign ex_ovf           = alu_ovf;
    assign ex_w_reg_ena     = id2_w_reg_ena & ~alu_ovf; // Overflowing op never writes back.
    assign ex_in_delay_slot = id2_in_delay_slot;
    assign ex_pc            = id2_pc;
    assign ex_rt_data       = id2_rt_data;
    assign ex_w_reg_dst     = id2_w_reg_dst;
    assign ex_wb_reg_sel    = id2_wb_reg_sel;

endmodule

`default_nettype wire

// ==== logic/ex_mem_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_mem_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  ex_pkg::word_t     ex_alu_res,
    input  logic              ex_ovf,
    input  logic              ex_in_delay_slot,
    input  ex_pkg::word_t     ex_pc,
    input  ex_pkg::word_t     ex_rt_data,
    input  logic              ex_w_reg_ena,
    input  ex_pkg::reg_addr_t ex_w_reg_dst,
    input  logic              ex_wb_reg_sel,
    output ex_pkg::word_t     mem_alu_res,
    output logic              mem_ovf,
    output logic              mem_in_delay_slot,
    output ex_pkg::word_t     mem_pc,
    output ex_pkg::word_t     mem_rt_data,
    output logic              mem_w_reg_ena,
    output ex_pkg::reg_addr_t mem_w_reg_dst,
    output logic              mem_wb_reg_sel
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_alu_res       <= '0;
            mem_ovf           <= 1'b0;
            mem_in_delay_slot <= 1'b0;
            mem_pc            <= '0;
            mem_rt_data       <= '0;
            mem_w_reg_ena     <= 1'b0;
            mem_w_reg_dst     <= '0;
            mem_wb_reg_sel    <= 1'b0;
        end else if (!stall) begin // Hold everything while stalled.
            mem_alu_res       <= ex_alu_res;
            mem_ovf           <= ex_ovf;
            mem_in_delay_slot <= ex_in_delay_slot;
            mem_pc            <= ex_pc;
            mem_rt_data       <= ex_rt_data;
            mem_w_reg_ena     <= ex_w_reg_ena;
            mem_w_reg_dst     <= ex_w_reg_dst;
            mem_wb_reg_sel    <= ex_wb_reg_sel;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ex_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               id2_in_delay_slot,
    input  ex_pkg::reg_addr_t  id2_w_reg_dst,
    input  ex_pkg::reg_addr_t  id2_sa,
    input  ex_pkg::word_t      id2_rs_data,
    input  ex_pkg::word_t      id2_rt_data,
    input  ex_pkg::word_t      id2_ext_imme,
    input  ex_pkg::word_t      id2_pc,
    input  ex_pkg::src_a_sel_t id2_src_a_sel,
    input  ex_pkg::src_b_sel_t id2_src_b_sel,
    input  ex_pkg::alu_sel_t   id2_alu_sel,
    input  ex_pkg::res_sel_t   id2_alu_res_sel,
    input  logic               id2_w_reg_ena,
    input  logic               id2_wb_reg_sel,
    output ex_pkg::word_t      mem_alu_res,
    output logic               mem_ovf,
    output logic               mem_in_delay_slot,
    output ex_pkg::word_t      mem_pc,
    output ex_pkg::word_t      mem_rt_data,
    output logic               mem_w_reg_ena,
    output ex_pkg::reg_addr_t  mem_w_reg_dst,
    output logic               mem_wb_reg_sel
);

    ex_pkg::word_t     ex_alu_res;
    logic              ex_ovf;
    logic              ex_in_delay_slot;
    ex_pkg::word_t     ex_pc;
    ex_pkg::word_t     ex_rt_data;
    logic              ex_w_reg_ena;
    ex_pkg::reg_addr_t ex_w_reg_dst;
    logic              ex_wb_reg_sel;

    ex_stage u_ex_stage (
        .id2_in_delay_slot (id2_in_delay_slot),
        .id2_w_reg_dst     (id2_w_reg_dst),
        .id2_sa            (id2_sa),
        .id2_rs_data       (id2_rs_data),
        .id2_rt_data       (id2_rt_data),
        .id2_ext_imme      (id2_ext_imme),
        .id2_pc            (id2_pc),
        .id2_src_a_sel     (id2_src_a_sel),
        .id2_src_b_sel     (id2_src_b_sel),
        .id2_alu_sel       (id2_alu_sel),
        .id2_alu_res_sel   (id2_alu_res_sel),
        .id2_w_reg_ena     (id2_w_reg_ena),
        .id2_wb_reg_sel    (id2_wb_reg_sel),
        .ex_alu_res        (ex_alu_res),
        .ex_ovf            (ex_ovf),
        .ex_in_delay_slot  (ex_in_delay_slot),
        .ex_pc             (ex_pc),
        .ex_rt_data        (ex_rt_data),
        .ex_w_reg_ena      (ex_w_reg_ena),
        .ex_w_reg_dst      (ex_w_reg_dst),
        .ex_wb_reg_sel     (ex_wb_reg_sel)
    );

    // Single pipeline register toward the memory stage.
    ex_mem_reg u_ex_mem_reg (
        .clk               (clk),
        .rst_n             (rst_n),
        .stall             (stall),
        .ex_alu_res        (ex_alu_res),
        .ex_ovf            (ex_ovf),
        .ex_in_delay_slot  (ex_in_delay_slot),
        .ex_pc             (ex_pc),
        .ex_rt_data        (ex_rt_data),
        .ex_w_reg_ena      (ex_w_reg_ena),
        .ex_w_reg_dst      (ex_w_reg_dst),
        .ex_wb_reg_sel     (ex_wb_reg_sel),
        .mem_alu_res       (mem_alu_res),
        .mem_ovf           (mem_ovf),
        .mem_in_delay_slot (mem_in_delay_slot),
        .mem_pc            (mem_pc),
        .mem_rt_data       (mem_rt_data),
        .mem_w_reg_ena     (mem_w_reg_ena),
        .mem_w_reg_dst     (mem_w_reg_dst),
        .mem_wb_reg_sel    (mem_wb_reg_sel)
    );

endmodule

`default_nettype wire

// ==== test/ex_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_tb;

    typedef struct packed {
        ex_pkg::word_t      rs;
        ex_pkg::word_t      rt;
        ex_pkg::word_t      imme;
        ex_pkg::reg_addr_t  sa;
        ex_pkg::src_a_sel_t a_sel;
        ex_pkg::src_b_sel_t b_sel;
        ex_pkg::alu_sel_t   alu_sel;
        ex_pkg::res_sel_t   res_sel;
        logic               w_ena;
        logic               stall;
        ex_pkg::word_t      exp_res;
        logic               exp_ovf;
        logic               exp_w_ena;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               stall;
    logic               id2_in_delay_slot;
    ex_pkg::reg_addr_t  id2_w_reg_dst;
    ex_pkg::reg_addr_t  id2_sa;
    ex_pkg::word_t      id2_rs_data;
    ex_pkg::word_t      id2_rt_data;
    ex_pkg::word_t      id2_ext_imme;
    ex_pkg::word_t      id2_pc;
    ex_pkg::src_a_sel_t id2_src_a_sel;
    ex_pkg::src_b_sel_t id2_src_b_sel;
    ex_pkg::alu_sel_t   id2_alu_sel;
    ex_pkg::res_sel_t   id2_alu_res_sel;
    logic               id2_w_reg_ena;
    logic               id2_wb_reg_sel;
    ex_pkg::word_t      mem_alu_res;
    logic               mem_ovf;
    logic               mem_in_delay_slot;
    ex_pkg::word_t      mem_pc;
    ex_pkg::word_t      mem_rt_data;
    logic               mem_w_reg_ena;
    ex_pkg::reg_addr_t  mem_w_reg_dst;
    logic               mem_wb_reg_sel;

    row_t rows[$];

    ex_top uut (.*);

    always #4 clk = ~clk; // 8 ns period.

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(string name, ex_pkg::word_t got, ex_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_reg(string name, ex_pkg::reg_addr_t got, ex_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Counts falling clock edges by polling in 1 ns steps.
    task automatic wait_falling_edges(int n);
        int   seen;
        int   ticks;
        logic prev;
        seen  = 0;
        ticks = 0;
        prev  = clk;
        while (seen < n) begin
            #1;
            ticks++;
            if (prev && !clk)
                seen++;
            prev = clk;
            if (ticks > n * 8 + 16) begin
                $display("Timeout: the clock stopped toggling at %0t ns.", $time);
                stop_run();
            end
        end
    endtask

    task automatic check_outputs(ex_pkg::word_t res, logic ovf, logic w_ena, ex_pkg::word_t pc,
                                 ex_pkg::word_t rt, ex_pkg::reg_addr_t dst, logic wb,
                                 logic dly);
        check_word("mem_alu_res", mem_alu_res, res);
        check_bit("mem_ovf", mem_ovf, ovf);
        check_bit("mem_w_reg_ena", mem_w_reg_ena, w_ena);
        check_word("mem_pc", mem_pc, pc);
        check_word("mem_rt_data", mem_rt_data, rt);
        check_reg("mem_w_reg_dst", mem_w_reg_dst, dst);
        check_bit("mem_wb_reg_sel", mem_wb_reg_sel, wb);
        check_bit("mem_in_delay_slot", mem_in_delay_slot, dly);
    endtask

    task automatic build_table();
        // Columns: rs, rt, imme, sa, a_sel, b_sel, alu_sel, res_sel, w_ena, stall,
        // expected result, overflow and write enable.
        rows.push_back('{32'h0000_0005, 32'h0000_0007, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_RT, ex_pkg::ALU_ADD, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h0000_000c, 1'b0, 1'b1});
        rows.push_back('{32'h0000_0010, 32'h0, 32'hffff_fff0, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_IMME, ex_pkg::ALU_ADDU, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h0000_0000, 1'b0, 1'b1});
        rows.push_back('{32'h0000_0003, 32'h0000_000a, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RT, ex_pkg::SRC_B_SEL_RS, ex_pkg::ALU_SUBU, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h0000_0007, 1'b0, 1'b1});
        rows.push_back('{32'hf0f0_f0f0, 32'hff00_ff00, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_RT, ex_pkg::ALU_AND, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'hf000_f000, 1'b0, 1'b1});
        rows.push_back('{32'hffff_ffff, 32'h0000_1234, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_ZERO, ex_pkg::SRC_B_SEL_RT, ex_pkg::ALU_OR, ex_pkg::RES_SEL_ALU,
            1'b0, 1'b0, 32'h0000_1234, 1'b0, 1'b0});
        rows.push_back('{32'haaaa_aaaa, 32'h0, 32'hffff_0000, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_IMME, ex_pkg::ALU_XOR, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h5555_aaaa, 1'b0, 1'b1});
        rows.push_back('{32'h0f0f_0000, 32'hffff_ffff, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_NOP, ex_pkg::ALU_NOR, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'hf0f0_ffff, 1'b0, 1'b1});
        rows.push_back('{32'hffff_ffff, 32'h0000_0001, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_RT, ex_pkg::ALU_SLT, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h0000_0001, 1'b0, 1'b1});
        rows.push_back('{32'hffff_ffff, 32'h0000_0001, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_RT, ex_pkg::ALU_SLTU, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h0000_0000, 1'b0, 1'b1});
        rows.push_back('{32'h1111_1111, 32'h0, 32'h0000_beef, 5'd0,
            ex_pkg::SRC_A_SEL_NOP, ex_pkg::SRC_B_SEL_IMME, ex_pkg::ALU_LUI, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'hbeef_0000, 1'b0, 1'b1});
        rows.push_back('{32'h0, 32'h0000_0001, 32'h0, 5'd31,
            ex_pkg::SRC_A_SEL_RT, ex_pkg::SRC_B_SEL_SA, ex_pkg::ALU_SLL, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h8000_0000, 1'b0, 1'b1});
        rows.push_back('{32'h0, 32'h8000_0000, 32'h0, 5'd4,
            ex_pkg::SRC_A_SEL_RT, ex_pkg::SRC_B_SEL_SA, ex_pkg::ALU_SRL, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h0800_0000, 1'b0, 1'b1});
        rows.push_back('{32'h0, 32'h8000_0000, 32'h0, 5'd4,
            ex_pkg::SRC_A_SEL_RT, ex_pkg::SRC_B_SEL_SA, ex_pkg::ALU_SRA, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'hf800_0000, 1'b0, 1'b1});
        // Only the low 5 bits of rs count as the amount.
        rows.push_back('{32'h0000_0024, 32'hf000_0000, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RT, ex_pkg::SRC_B_SEL_RS, ex_pkg::ALU_SRA, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'hff00_0000, 1'b0, 1'b1});
        rows.push_back('{32'hffff_ffe8, 32'h0000_00ab, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RT, ex_pkg::SRC_B_SEL_RS, ex_pkg::ALU_SLL, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h0000_ab00, 1'b0, 1'b1});
        rows.push_back('{32'h7fff_ffff, 32'h0000_0001, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_RT, ex_pkg::ALU_ADD, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h8000_0000, 1'b1, 1'b0});
        rows.push_back('{32'h8000_0000, 32'h0000_0001, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_RT, ex_pkg::ALU_SUB, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h7fff_ffff, 1'b1, 1'b0});
        rows.push_back('{32'h7fff_ffff, 32'h0000_0001, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_RT, ex_pkg::ALU_ADDU, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h8000_0000, 1'b0, 1'b1});
        // Link rows take their result from the PC in the loop.
        rows.push_back('{32'h0, 32'h0, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_ZERO, ex_pkg::SRC_B_SEL_ZERO, ex_pkg::ALU_ADD, ex_pkg::RES_SEL_LINK,
            1'b1, 1'b0, 32'h0, 1'b0, 1'b1});
        rows.push_back('{32'h0000_0064, 32'h0000_00c8, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_RT, ex_pkg::ALU_ADD, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b1, 32'h0, 1'b0, 1'b0});
        rows.push_back('{32'h0000_0064, 32'h0000_00c8, 32'h0, 5'd0,
            ex_pkg::SRC_A_SEL_RS, ex_pkg::SRC_B_SEL_RT, ex_pkg::ALU_ADD, ex_pkg::RES_SEL_ALU,
            1'b1, 1'b0, 32'h0000_012c, 1'b0, 1'b1});
    endtask

    initial begin
        ex_pkg::word_t     q_res;
        logic              q_ovf;
        logic              q_w_ena;
        ex_pkg::word_t     q_pc;
        ex_pkg::word_t     q_rt;
        ex_pkg::reg_addr_t q_dst;
        logic              q_wb;
        logic              q_dly;
        row_t              r;
        ex_pkg::word_t     pc;

        clk               = 1'b0;
        rst_n             = 1'b0;
        stall             = 1'b0;
        id2_in_delay_slot = 1'b0;
        id2_w_reg_dst     = '0;
        id2_sa            = '0;
        id2_rs_data       = '0;
        id2_rt_data       = '0;
        id2_ext_imme      = '0;
        id2_pc            = '0;
        id2_src_a_sel     = ex_pkg::SRC_A_SEL_NOP;
        id2_src_b_sel     = ex_pkg::SRC_B_SEL_NOP;
        id2_alu_sel       = '0;
        id2_alu_res_sel   = ex_pkg::RES_SEL_NOP;
        id2_w_reg_ena     = 1'b0;
        id2_wb_reg_sel    = 1'b0;
        build_table();

        wait_falling_edges(2);
        check_outputs('0, 1'b0, 1'b0, '0, '0, '0, 1'b0, 1'b0); // Inside reset.
        wait_falling_edges(6);
        rst_n = 1'b1;

        q_res   = '0;
        q_ovf   = 1'b0;
        q_w_ena = 1'b0;
        q_pc    = '0;
        q_rt    = '0;
        q_dst   = '0;
        q_wb    = 1'b0;
        q_dly   = 1'b0;

        foreach (rows[i]) begin
            r  = rows[i];
            pc = 32'h0040_0000 + 32'(i) * 4;
            wait_falling_edges(1);
            // Registered values of the previous row, reset values the first time.
            check_outputs(q_res, q_ovf, q_w_ena, q_pc, q_rt, q_dst, q_wb, q_dly);
            id2_rs_data       = r.rs;
            id2_rt_data       = r.rt;
            id2_ext_imme      = r.imme;
            id2_sa            = r.sa;
            id2_src_a_sel     = r.a_sel;
            id2_src_b_sel     = r.b_sel;
            id2_alu_sel       = r.alu_sel;
            id2_alu_res_sel   = r.res_sel;
            id2_w_reg_ena     = r.w_ena;
            stall             = r.stall;
            id2_pc            = pc;
            id2_w_reg_dst     = ex_pkg::reg_addr_t'(i + 1);
            id2_wb_reg_sel    = i[0];
            id2_in_delay_slot = i[1];
            if (!r.stall) begin // A stalled row leaves the expected values alone.
                q_res   = (r.res_sel == ex_pkg::RES_SEL_LINK) ? pc + ex_pkg::LINK_OFFSET
                                                             : r.exp_res;
                q_ovf   = r.exp_ovf;
                q_w_ena = r.exp_w_ena;
                q_pc    = pc;
                q_rt    = r.rt;
                q_dst   = ex_pkg::reg_addr_t'(i + 1);
                q_wb    = i[0];
                q_dly   = i[1];
            end
        end

        wait_falling_edges(1);
        check_outputs(q_res, q_ovf, q_w_ena, q_pc, q_rt, q_dst, q_wb, q_dly);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/ex_pkg.sv
logic/alu_shifter.sv
logic/alu.sv
logic/ex_stage.sv
logic/ex_mem_reg.sv
logic/ex_top.sv
test/ex_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - logic/ex_pkg.sv
  - logic/alu_shifter.sv
  - logic/alu.sv
  - logic/ex_stage.sv
  - logic/ex_mem_reg.sv
  - logic/ex_top.sv
  - target: test
    files:
      - test/ex_tb.sv
